/* src/rv32i_types.sv */
package rv32i_types;

    // funct3 of RV32I loads and stores
    // stores only use lb, lh and lw
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } mem_funct3_e;

    // data memory controller states
    typedef enum logic [1:0] {
        idle      = 2'b00,
        drain     = 2'b01,
        load_wait = 2'b10,
        load_read = 2'b11
    } ctrl_state_e;

    // store buffer geometry
    localparam int sb_depth = 4;
    localparam int sb_idx_w = 2;

endpackage : rv32i_types

/* src/store_align.sv */
`timescale 1ns/1ps

module store_align (
    input  rv32i_types::mem_funct3_e funct3,
    input  logic [1:0]               addr,
    input  logic [31:0]              wdata,
    output logic [31:0]              data,
    output logic [3:0]               sel,
    output logic [3:0]               load_sel
);

    import rv32i_types::*;

    // store lanes, only the three store widths are valid
    always_comb begin
        data = wdata;
        sel  = 4'b0000;
        case (funct3)
            lb: begin
                data = {4{wdata[7:0]}};
                sel  = 4'b0001 << addr;
            end
            lh: begin
                data = {2{wdata[15:0]}};
                sel  = addr[1] ? 4'b1100 : 4'b0011;
            end
            lw: begin
                data = wdata;
                sel  = 4'b1111;
            end
            default: begin
                data = wdata;
                sel  = 4'b0000;
            end
        endcase
    end

    // lanes a load needs, the sign bit does not matter here
    always_comb begin
        case (funct3[1:0])
            2'b00:   load_sel = 4'b0001 << addr;
            2'b01:   load_sel = addr[1] ? 4'b1100 : 4'b0011;
            default: load_sel = 4'b1111;
        endcase
    end

endmodule : store_align

/* src/load_align.sv */
`timescale 1ns/1ps

module load_align (
    input  rv32i_types::mem_funct3_e funct3,
    input  logic [1:0]               addr,
    input  logic [31:0]              word,
    output logic [31:0]              data
);

    import rv32i_types::*;

    logic [31:0] shifted;

    // addressed byte or halfword down to lane 0
    assign shifted = word >> {addr, 3'b000};

    always_comb begin
        case (funct3)
            lb: begin
                data = {{24{shifted[7]}}, shifted[7:0]};
            end
            lbu: begin
                data = {24'h000000, shifted[7:0]};
            end
            lh: begin
                data = {{16{shifted[15]}}, shifted[15:0]};
            end
            lhu: begin
                data = {16'h0000, shifted[15:0]};
            end
            default: begin
                // lw, address is word aligned so no shift took place
                data = shifted;
            end
        endcase
    end

endmodule : load_align

/* src/store_buffer.sv */
`timescale 1ns/1ps

module store_buffer (
    input  logic        clk,
    input  logic        rst,

    // core side
    input  logic        push,
    input  logic [31:0] wr_addr,
    input  logic [31:0] wr_data,
    input  logic [3:0]  wr_sel,

    // drain side
    input  logic        pop,

    // load lookup
    input  logic [31:0] lk_addr,
    input  logic [3:0]  lk_sel,

    output logic        full,
    output logic        empty,
    output logic [31:0] head_addr,
    output logic [31:0] head_data,
    output logic [3:0]  head_sel,
    output logic        fwd_hit,
    output logic        fwd_block,
    output logic [31:0] fwd_data
);

    import rv32i_types::*;

    logic [29:0]         addr_q [sb_depth];
    logic [31:0]         data_q [sb_depth];
    logic [3:0]          sel_q  [sb_depth];

    logic [sb_idx_w-1:0] head;
    logic [sb_idx_w-1:0] tail;
    logic [sb_idx_w:0]   count;

    logic                lk_match;
    logic [sb_idx_w-1:0] lk_idx;
    logic [sb_idx_w-1:0] scan_idx;

    assign full  = (count == (sb_idx_w + 1)'(sb_depth));
    assign empty = (count == '0);

    // entry payload, written at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[tail] <= wr_addr[31:2];
            data_q[tail] <= wr_data;
            sel_q[tail]  <= wr_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_addr = {addr_q[head], 2'b00};
    assign head_data = data_q[head];
    assign head_sel  = sel_q[head];

    // walk oldest to newest, the last match is the newest store
    always_comb begin
        lk_match = 1'b0;
        lk_idx   = head;
        scan_idx = head;
        for (int i = 0; i < sb_depth; i++) begin
            scan_idx = head + sb_idx_w'(i);
            if (((sb_idx_w + 1)'(i) < count) && (addr_q[scan_idx] == lk_addr[31:2])) begin
                lk_match = 1'b1;
                lk_idx   = scan_idx;
            end
        end
    end

    assign fwd_hit   = lk_match && ((sel_q[lk_idx] & lk_sel) == lk_sel);
    assign fwd_block = lk_match && ((sel_q[lk_idx] & lk_sel) != lk_sel);
    assign fwd_data  = data_q[lk_idx];

    // controller must respect full and empty
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("store buffer push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("store buffer pop while empty");

endmodule : store_buffer

/* src/mem_ctrl.sv */
`timescale 1ns/1ps

module mem_ctrl (
    input  logic                     clk,
    input  logic                     rst,

    // core side
    input  logic                     cpu_req,
    input  logic                     cpu_we,
    input  rv32i_types::mem_funct3_e cpu_funct3,
    input  logic [31:0]              cpu_addr,
    output logic                     cpu_ready,
    output logic                     cpu_rvalid,
    output logic [31:0]              cpu_rdata,

    // store buffer
    input  logic                     full,
    input  logic                     empty,
    input  logic                     fwd_hit,
    input  logic                     fwd_block,
    output logic                     push,
    output logic                     pop,
    input  logic [31:0]              head_addr,
    input  logic [3:0]               head_sel,

    // load aligner
    input  logic [31:0]              ld_data,
    output logic                     ld_src,
    output logic [31:0]              ld_addr,
    output rv32i_types::mem_funct3_e ld_funct3,

    // wishbone master
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [31:0]              wb_adr,
    output logic [3:0]               wb_sel,
    input  logic                     wb_ack
);

    import rv32i_types::*;

    ctrl_state_e state;
    logic        load_free;
    logic        load_acc;
    logic        load_miss;
    logic [31:0] rdata_q;

    // a held load blocks every new request
    assign load_free = (state == idle) || (state == drain);
    assign cpu_ready = cpu_we ? (load_free && !full) : load_free;

    assign push      = cpu_req && cpu_ready && cpu_we;
    assign load_acc  = cpu_req && cpu_ready && !cpu_we;
    assign load_miss = load_acc && (fwd_block || !fwd_hit);

    // stores retire on their ack
    assign pop = wb_cyc && wb_we && wb_ack;

    // forwarded data in idle and drain, bus data in load_read
    assign ld_src = (state != load_read);

    assign wb_adr = (state == load_read) ? {ld_addr[31:2], 2'b00} : head_addr;
    assign wb_sel = (state == load_read) ? 4'b1111 : head_sel;

    assign cpu_rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= idle;
            wb_cyc     <= 1'b0;
            wb_stb     <= 1'b0;
            wb_we      <= 1'b0;
            cpu_rvalid <= 1'b0;
        end else begin
            cpu_rvalid <= 1'b0;
            case (state)
                idle: begin
                    if (load_miss) begin
                        state <= load_wait;
                    end else if (!empty) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= 1'b1;
                        state  <= drain;
                    end
                end
                drain: begin
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                    end
                    if (load_miss) begin
                        state <= load_wait;
                    end else if (wb_ack) begin
                        state <= idle;
                    end
                end
                load_wait: begin
                    // finish the buffer before the read goes out
                    if (wb_cyc) begin
                        if (wb_ack) begin
                            wb_cyc <= 1'b0;
                            wb_stb <= 1'b0;
                        end
                    end else if (!empty) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= 1'b1;
                    end else begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= 1'b0;
                        state  <= load_read;
                    end
                end
                load_read: begin
                    if (wb_ack) begin
                        wb_cyc     <= 1'b0;
                        wb_stb     <= 1'b0;
                        cpu_rvalid <= 1'b1;
                        state      <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase

            if (load_acc && fwd_hit) begin
                cpu_rvalid <= 1'b1;
            end
        end
    end

    // load result and held load, payload only
    always_ff @(posedge clk) begin
        if ((load_acc && fwd_hit) || (state == load_read && wb_ack)) begin
            rdata_q <= ld_data;
        end
        if (load_miss) begin
            ld_addr   <= cpu_addr;
            ld_funct3 <= cpu_funct3;
        end
    end

    a_stb_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("wb_stb without wb_cyc");

    a_adr_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> $stable(wb_adr))
        else $error("wb_adr changed during a bus cycle");

endmodule : mem_ctrl

/* src/mem_stage_top.sv */
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                     clk,
    input  logic                     rst,

    // core load/store unit
    input  logic                     cpu_req,
    input  logic                     cpu_we,
    input  rv32i_types::mem_funct3_e cpu_funct3,
    input  logic [31:0]              cpu_addr,
    input  logic [31:0]              cpu_wdata,
    output logic                     cpu_ready,
    output logic                     cpu_rvalid,
    output logic [31:0]              cpu_rdata,

    // wishbone classic master
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [31:0]              wb_adr,
    output logic [31:0]              wb_dat_o,
    output logic [3:0]               wb_sel,
    input  logic [31:0]              wb_dat_i,
    input  logic                     wb_ack
);

    import rv32i_types::*;

    logic [31:0] sa_data;
    logic [3:0]  sa_sel;
    logic [3:0]  lk_sel;

    logic        push;
    logic        pop;
    logic        full;
    logic        empty;
    logic        fwd_hit;
    logic        fwd_block;
    logic [31:0] fwd_data;
    logic [31:0] head_addr;
    logic [31:0] head_data;
    logic [3:0]  head_sel;

    logic        ld_src;
    logic [31:0] ld_addr;
    mem_funct3_e ld_funct3;
    logic [31:0] ld_data;

    mem_funct3_e la_funct3;
    logic [1:0]  la_addr;
    logic [31:0] la_word;

    store_align u_store_align (
        .funct3   (cpu_funct3),
        .addr     (cpu_addr[1:0]),
        .wdata    (cpu_wdata),
        .data     (sa_data),
        .sel      (sa_sel),
        .load_sel (lk_sel)
    );

    store_buffer u_store_buffer (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .wr_addr   (cpu_addr),
        .wr_data   (sa_data),
        .wr_sel    (sa_sel),
        .pop       (pop),
        .lk_addr   (cpu_addr),
        .lk_sel    (lk_sel),
        .full      (full),
        .empty     (empty),
        .head_addr (head_addr),
        .head_data (head_data),
        .head_sel  (head_sel),
        .fwd_hit   (fwd_hit),
        .fwd_block (fwd_block),
        .fwd_data  (fwd_data)
    );

    mem_ctrl u_mem_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_we     (cpu_we),
        .cpu_funct3 (cpu_funct3),
        .cpu_addr   (cpu_addr),
        .cpu_ready  (cpu_ready),
        .cpu_rvalid (cpu_rvalid),
        .cpu_rdata  (cpu_rdata),
        .full       (full),
        .empty      (empty),
        .fwd_hit    (fwd_hit),
        .fwd_block  (fwd_block),
        .push       (push),
        .pop        (pop),
        .head_addr  (head_addr),
        .head_sel   (head_sel),
        .ld_data    (ld_data),
        .ld_src     (ld_src),
        .ld_addr    (ld_addr),
        .ld_funct3  (ld_funct3),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_sel     (wb_sel),
        .wb_ack     (wb_ack)
    );

    // forwarding uses the live request, a bus read uses the held load
    assign la_funct3 = ld_src ? cpu_funct3    : ld_funct3;
    assign la_addr   = ld_src ? cpu_addr[1:0] : ld_addr[1:0];
    assign la_word   = ld_src ? fwd_data      : wb_dat_i;

    load_align u_load_align (
        .funct3 (la_funct3),
        .addr   (la_addr),
        .word   (la_word),
        .data   (ld_data)
    );

    assign wb_dat_o = head_data;

endmodule : mem_stage_top

/* testbench/wb_mem_model.sv */
`timescale 1ns/1ps

module wb_mem_model (
    input  logic        clk,
    input  logic        rst,

    // wishbone classic slave
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [31:0] dat_i,
    input  logic [3:0]  sel,
    output logic [31:0] dat_o,
    output logic        ack,

    // backdoor read of one word
    input  logic [3:0]  bd_addr,
    output logic [31:0] bd_data
);

    logic [31:0] mem [16];
    logic        busy;
    logic [1:0]  wait_cnt;

    always @(posedge clk) begin
        if (rst) begin
            ack      <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= 2'd0;
            dat_o    <= '0;
            // every byte gets a value derived from its own address
            for (int i = 0; i < 16; i++) begin
                for (int b = 0; b < 4; b++) begin
                    mem[i][8*b +: 8] <= 8'((4 * i + b) * 37) ^ 8'h5a;
                end
            end
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !ack) begin
                if (!busy) begin
                    busy     <= 1'b1;
                    wait_cnt <= 2'($urandom_range(0, 3));
                end else if (wait_cnt != 2'd0) begin
                    wait_cnt <= wait_cnt - 2'd1;
                end else begin
                    busy <= 1'b0;
                    ack  <= 1'b1;
                    if (we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (sel[b]) begin
                                mem[adr[5:2]][8*b +: 8] <= dat_i[8*b +: 8];
                            end
                        end
                    end else begin
                        dat_o <= mem[adr[5:2]];
                    end
                end
            end
        end
    end

    assign bd_data = mem[bd_addr];

endmodule : wb_mem_model

/* testbench/tb_mem_stage.sv */
`timescale 1ns/1ps

module tb_mem_stage;

    import rv32i_types::*;

    localparam logic [31:0] region_base = 32'h0000_1000;
    localparam int          num_ops     = 600;
    localparam int          wait_limit  = 200;

    logic        clk;
    logic        rst;
    logic        cpu_req;
    logic        cpu_we;
    mem_funct3_e cpu_funct3;
    logic [31:0] cpu_addr;
    logic [31:0] cpu_wdata;
    logic        cpu_ready;
    logic        cpu_rvalid;
    logic [31:0] cpu_rdata;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_o;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_i;
    logic        wb_ack;
    logic [3:0]  bd_addr;
    logic [31:0] bd_data;

    // shadow memory and the stores still in the buffer, oldest first
    logic [7:0]  shadow [64];
    logic [29:0] sq_word [$];
    logic [3:0]  sq_sel [$];
    logic [31:0] sq_data [$];

    logic        seen_req;
    logic        rvalid_due;
    logic        miss_pending;
    logic [29:0] miss_word;
    logic [31:0] exp_rdata;
    logic        hold_valid;
    logic [31:0] hold_adr;
    logic [31:0] hold_dat;
    logic [3:0]  hold_sel;
    logic        hold_we;

    int mon_errors    = 0;
    int end_errors    = 0;
    int timeouts      = 0;
    int fwd_loads     = 0;
    int blocked_loads = 0;
    int bus_reads     = 0;
    int full_stalls   = 0;

    mem_stage_top dut (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_we     (cpu_we),
        .cpu_funct3 (cpu_funct3),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_ready  (cpu_ready),
        .cpu_rvalid (cpu_rvalid),
        .cpu_rdata  (cpu_rdata),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_o   (wb_dat_o),
        .wb_sel     (wb_sel),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack)
    );

    wb_mem_model u_mem (
        .clk     (clk),
        .rst     (rst),
        .cyc     (wb_cyc),
        .stb     (wb_stb),
        .we      (wb_we),
        .adr     (wb_adr),
        .dat_i   (wb_dat_o),
        .sel     (wb_sel),
        .dat_o   (wb_dat_i),
        .ack     (wb_ack),
        .bd_addr (bd_addr),
        .bd_data (bd_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic void flag_mismatch(input string msg);
        mon_errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endfunction

    // byte lanes touched by an access of this width
    function automatic logic [3:0] lane_mask(input mem_funct3_e f3, input logic [1:0] off);
        case (f3)
            lb, lbu: return 4'b0001 << off;
            lh, lhu: return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] store_lanes(input mem_funct3_e f3, input logic [1:0] off,
                                                input logic [31:0] wdata);
        case (f3)
            lb:      return {24'h000000, wdata[7:0]} << (8 * off);
            lh:      return {16'h0000, wdata[15:0]} << (8 * off);
            default: return wdata;
        endcase
    endfunction

    function automatic logic [31:0] expected_load(input mem_funct3_e f3, input logic [5:0] a);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = shadow[a];
        b1 = shadow[a + 6'd1];
        case (f3)
            lb:      return {{24{b0[7]}}, b0};
            lbu:     return {24'h000000, b0};
            lh:      return {{16{b1[7]}}, b1, b0};
            lhu:     return {16'h0000, b1, b0};
            default: return {shadow[a + 6'd3], shadow[a + 6'd2], b1, b0};
        endcase
    endfunction

    function automatic mem_funct3_e pick_load(input logic [1:0] width, input logic sign);
        if (width == 2'd0) return sign ? lb : lbu;
        if (width == 2'd1) return sign ? lh : lhu;
        return lw;
    endfunction

    always @(posedge clk) begin
        logic [5:0]  off;
        logic [3:0]  need;
        logic [31:0] lanes;
        logic [29:0] f_word;
        logic [3:0]  f_sel;
        logic [31:0] f_data;
        logic        found;
        logic        covered;
        logic        exp_ready;
        if (rst) begin
            for (int a = 0; a < 64; a++) begin
                shadow[a] = 8'(a * 37) ^ 8'h5a;
            end
            sq_word.delete();
            sq_sel.delete();
            sq_data.delete();
            seen_req     = 1'b0;
            rvalid_due   = 1'b0;
            miss_pending = 1'b0;
            hold_valid   = 1'b0;
        end else begin
            off = cpu_addr[5:0];
            if (!seen_req) begin
                assert (!wb_cyc && !wb_stb && !cpu_rvalid)
                    else flag_mismatch("bus or rvalid active before the first request");
                seen_req = cpu_req;
            end

            assert (cpu_rvalid == rvalid_due)
                else flag_mismatch($sformatf("cpu_rvalid is %0b, expected %0b",
                                             cpu_rvalid, rvalid_due));
            if (cpu_rvalid && rvalid_due) begin
                assert (cpu_rdata == exp_rdata)
                    else flag_mismatch($sformatf("load data %h, expected %h",
                                                 cpu_rdata, exp_rdata));
            end
            rvalid_due = 1'b0;

            // a pending miss stalls everything, a full buffer stalls stores
            if (cpu_req) begin
                exp_ready = !miss_pending && !(cpu_we && sq_word.size() == sb_depth);
                assert (cpu_ready == exp_ready)
                    else flag_mismatch($sformatf("cpu_ready is %0b, expected %0b",
                                                 cpu_ready, exp_ready));
                if (cpu_we && sq_word.size() == sb_depth) full_stalls++;
            end

            if (hold_valid) begin
                assert (wb_stb && wb_adr == hold_adr && wb_sel == hold_sel &&
                        wb_we == hold_we && wb_dat_o == hold_dat)
                    else flag_mismatch("bus master outputs changed before ack");
            end
            hold_valid = wb_stb && !wb_ack;
            hold_adr   = wb_adr;
            hold_sel   = wb_sel;
            hold_we    = wb_we;
            hold_dat   = wb_dat_o;

            // lookup sees the buffer before this edge's pop
            if (cpu_req && cpu_ready && !cpu_we) begin
                need    = lane_mask(cpu_funct3, off[1:0]);
                found   = 1'b0;
                covered = 1'b0;
                for (int i = 0; i < sq_word.size(); i++) begin
                    if (sq_word[i] == cpu_addr[31:2]) begin
                        found   = 1'b1;
                        covered = ((sq_sel[i] & need) == need);
                    end
                end
                exp_rdata = expected_load(cpu_funct3, off);
                if (found && covered) begin
                    rvalid_due = 1'b1;
                    fwd_loads++;
                end else begin
                    miss_pending = 1'b1;
                    miss_word    = cpu_addr[31:2];
                    if (found) blocked_loads++;
                end
            end

            if (wb_cyc && wb_stb && wb_ack && wb_we) begin
                assert (sq_word.size() != 0)
                    else flag_mismatch("bus write with no store in the buffer");
                if (sq_word.size() != 0) begin
                    f_word = sq_word.pop_front();
                    f_sel  = sq_sel.pop_front();
                    f_data = sq_data.pop_front();
                    assert (wb_adr == {f_word, 2'b00} && wb_sel == f_sel)
                        else flag_mismatch($sformatf("bus write %h sel %b, expected %h sel %b",
                                                     wb_adr, wb_sel, {f_word, 2'b00}, f_sel));
                    assert (((wb_dat_o ^ f_data) & {{8{f_sel[3]}}, {8{f_sel[2]}},
                                                    {8{f_sel[1]}}, {8{f_sel[0]}}}) == '0)
                        else flag_mismatch($sformatf("bus write data %h, expected %h",
                                                     wb_dat_o, f_data));
                end
            end

            if (wb_cyc && wb_stb && wb_ack && !wb_we) begin
                assert (miss_pending && sq_word.size() == 0 &&
                        wb_adr == {miss_word, 2'b00} && wb_sel == 4'b1111)
                    else flag_mismatch($sformatf("unexpected bus read at %h", wb_adr));
                miss_pending = 1'b0;
                rvalid_due   = 1'b1;
                bus_reads++;
            end

            if (cpu_req && cpu_ready && cpu_we) begin
                need  = lane_mask(cpu_funct3, off[1:0]);
                lanes = store_lanes(cpu_funct3, off[1:0], cpu_wdata);
                sq_word.push_back(cpu_addr[31:2]);
                sq_sel.push_back(need);
                sq_data.push_back(lanes);
                for (int k = 0; k < 4; k++) begin
                    if (need[k]) shadow[{off[5:2], 2'(k)}] = lanes[8*k +: 8];
                end
            end
        end
    end

    // ready is looked at mid cycle, where it already holds its value for the next edge
    task automatic issue(input logic we, input mem_funct3_e f3, input logic [31:0] addr,
                         input logic [31:0] wdata);
        int waited;
        cpu_req    <= 1'b1;
        cpu_we     <= we;
        cpu_funct3 <= f3;
        cpu_addr   <= addr;
        cpu_wdata  <= wdata;
        waited = 0;
        @(negedge clk);
        while (!cpu_ready && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!cpu_ready) begin
            $display("timeout: request to %h at %0t was never accepted", addr, $time);
            timeouts++;
        end
        @(posedge clk);
        cpu_req <= 1'b0;
    endtask

    task automatic random_op();
        logic [1:0]  width;
        logic [5:0]  off;
        logic        sign;
        mem_funct3_e f3;
        width = 2'($urandom_range(0, 2));
        off   = 6'($urandom_range(0, 63));
        sign  = 1'($urandom_range(0, 1));
        if (width == 2'd1) off[0] = 1'b0;
        if (width == 2'd2) off[1:0] = 2'b00;
        if ($urandom_range(0, 1) == 1) begin
            f3 = (width == 2'd0) ? lb : ((width == 2'd1) ? lh : lw);
            issue(1'b1, f3, region_base + 32'(off), $urandom);
            // same bytes read right behind the store
            if ($urandom_range(0, 3) == 0) begin
                issue(1'b0, pick_load(width, sign), region_base + 32'(off), 32'h0);
            end
        end else begin
            issue(1'b0, pick_load(width, sign), region_base + 32'(off), 32'h0);
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while ((sq_word.size() != 0 || miss_pending || rvalid_due || wb_cyc) &&
               waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= wait_limit) begin
            $display("timeout: store buffer did not drain at %0t", $time);
            timeouts++;
        end
    endtask

    initial begin
        logic [31:0] word;
        int          holes;
        void'($urandom(32'h814c_3bd4));
        rst        = 1'b1;
        cpu_req    = 1'b0;
        cpu_we     = 1'b0;
        cpu_funct3 = lw;
        cpu_addr   = region_base;
        cpu_wdata  = 32'h0;
        bd_addr    = 4'h0;
        holes      = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);

        for (int n = 0; n < num_ops && timeouts == 0; n++) begin
            random_op();
            repeat ($urandom_range(0, 2)) @(posedge clk);
        end
        wait_idle();

        for (int i = 0; i < 16; i++) begin
            bd_addr = 4'(i);
            #1;
            word = {shadow[4*i+3], shadow[4*i+2], shadow[4*i+1], shadow[4*i]};
            assert (bd_data == word) else begin
                end_errors++;
                $display("CHECK FAILED at %0t: memory word %0d is %h, expected %h",
                         $time, i, bd_data, word);
            end
        end

        if (fwd_loads == 0) begin
            $display("coverage hole: no load was forwarded from the store buffer");
            holes++;
        end
        if (blocked_loads == 0) begin
            $display("coverage hole: no load met a partially covering store");
            holes++;
        end
        if (bus_reads == 0 || full_stalls == 0) begin
            $display("coverage hole: no bus read or no store stalled on a full buffer");
            holes++;
        end

        $display("errors: %0d, timeouts: %0d, coverage holes: %0d, forwarded: %0d, reads: %0d",
                 mon_errors + end_errors, timeouts, holes, fwd_loads, bus_reads);
        if (mon_errors + end_errors + timeouts + holes == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : tb_mem_stage

/* sim.f */
src/rv32i_types.sv
src/store_align.sv
src/load_align.sv
src/store_buffer.sv
src/mem_ctrl.sv
src/mem_stage_top.sv
testbench/wb_mem_model.sv
testbench/tb_mem_stage.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_mem_stage -o tb_mem_stage
./obj_dir/tb_mem_stage | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "simulation run ok"
else
    echo "simulation run reported errors"
    exit 1
fi
